//--- sim.f
+incdir+rtl
rtl/ccd_pkg.sv
rtl/ccd_exp_if.sv
rtl/ccd_trigger_ctrl.sv
rtl/ccd_exp.sv
rtl/ccd_readout_seq.sv
rtl/ccd_timing_top.sv
testbench/ccd_timing_checker.sv
testbench/tb_ccd_timing.sv

//--- Makefile
SRCS := $(shell grep -v '^+' sim.f) rtl/ccd_config.svh
BIN  := obj_dir/Vtb_ccd_timing

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module tb_ccd_timing -o Vtb_ccd_timing

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_ccd_timing.sv
`timescale 1ns/1ps
`include "ccd_config.svh"

module tb_ccd_timing;
	import ccd_pkg::*;

	localparam int N_TESTS   = 5;
	localparam int WAIT_MAX  = 4000;   // cycles, exposure plus full readout
	localparam int IDLE_WAIT = 200;    // quiet window after a triggered frame

	typedef struct {
		trig_mode_e mode;
		int         exposure;
		bit         extra_trig;      // second trigger during readout
		int         integ_cycles;    // max(exposure, 13)
		int         xsub_cycles;     // shutter low time, 0 in free-run
	} test_row_t;

	logic       pixclk;
	logic       reset;
	trig_mode_e trig_mode;
	logic       trigger;
	exp_cnt_t   exposure_reg;
	logic       xsub;
	logic       xsg;
	logic       strobe;
	logic       integration;
	logic       exp_over;
	logic       frame_done;
	line_cnt_t  vcount;

	int         test_idx;
	int         integ_exp;
	int         xsub_exp;
	logic       expect_idle;
	int         frames;
	int         errors;
	int         checks;
	bit         timed_out;
	int         i;
	test_row_t  tests [N_TESTS];

	initial begin
		pixclk = 1'b0;
		forever #2 pixclk = ~pixclk;   // 4 ns pixel clock
	end

	ccd_timing_top ccd_timing_top_inst (
		.pixclk         (pixclk),
		.reset          (reset),
		.i_trig_mode    (trig_mode),
		.i_trigger      (trigger),
		.i_exposure_reg (exposure_reg),
		.o_xsub         (xsub),
		.o_xsg          (xsg),
		.o_strobe       (strobe),
		.o_integration  (integration),
		.o_exp_over     (exp_over),
		.o_frame_done   (frame_done),
		.o_vcount       (vcount)
	);

	ccd_timing_checker ccd_timing_checker_inst (
		.pixclk         (pixclk),
		.reset          (reset),
		.i_xsub         (xsub),
		.i_xsg          (xsg),
		.i_strobe       (strobe),
		.i_integration  (integration),
		.i_exp_over     (exp_over),
		.i_frame_done   (frame_done),
		.i_vcount       (vcount),
		.i_test         (test_idx),
		.i_integ_cycles (integ_exp),
		.i_xsub_cycles  (xsub_exp),
		.i_expect_idle  (expect_idle),
		.o_frames       (frames),
		.o_errors       (errors),
		.o_checks       (checks)
	);

	// ------------------------------------------------------------
	// stimulus helpers, all on the falling edge
	// ------------------------------------------------------------
	task automatic pulse_trigger();
		trigger = 1'b1;
		repeat (4) @(negedge pixclk);
		trigger = 1'b0;
	endtask

	task automatic wait_readout();
		int n;
		n = 0;
		while (vcount == '0 && n < WAIT_MAX) begin
			@(negedge pixclk);
			n++;
		end
		if (vcount == '0) begin
			$display("timeout: readout never started on test %0d", test_idx);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames < target && n < WAIT_MAX) begin
			@(negedge pixclk);
			n++;
		end
		if (frames < target) begin
			$display("timeout: no frame_done on test %0d", test_idx);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		// mode, exposure, extra trigger, integration width, shutter low
		tests[0] = '{TRIG_EXTERNAL, 5,   1'b0, 13,  `XSUB_WIDTH};   // clamped
		tests[1] = '{TRIG_EXTERNAL, 40,  1'b1, 40,  `XSUB_WIDTH};
		tests[2] = '{TRIG_EXTERNAL, 100, 1'b0, 100, `XSUB_WIDTH};
		tests[3] = '{TRIG_FREERUN,  40,  1'b0, 40,  0};
		tests[4] = '{TRIG_FREERUN,  20,  1'b0, 20,  0};  // next frame, no trigger

		reset        = 1'b1;
		trig_mode    = TRIG_EXTERNAL;
		trigger      = 1'b0;
		exposure_reg = '0;
		test_idx     = 0;
		integ_exp    = 0;
		xsub_exp     = 0;
		expect_idle  = 1'b0;
		timed_out    = 1'b0;
		repeat (16) @(negedge pixclk);
		reset = 1'b0;

		for (i = 0; i < N_TESTS && !timed_out; i++) begin
			test_idx     = i;
			trig_mode    = tests[i].mode;
			exposure_reg = exp_cnt_t'(tests[i].exposure);
			integ_exp    = tests[i].integ_cycles;
			xsub_exp     = tests[i].xsub_cycles;
			if (tests[i].mode == TRIG_EXTERNAL)
				pulse_trigger();
			if (tests[i].extra_trig) begin
				wait_readout();
				if (!timed_out)
					pulse_trigger();    // must be dropped, frame busy
			end
			wait_frames(i + 1);
			if (!timed_out && tests[i].mode == TRIG_EXTERNAL) begin
				expect_idle = 1'b1;
				repeat (IDLE_WAIT) @(negedge pixclk);
				expect_idle = 1'b0;
			end
		end

		$display("tests %0d of %0d, checks %0d, errors %0d", frames, N_TESTS, checks, errors);
		if (errors == 0 && !timed_out && frames == N_TESTS)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- testbench/ccd_timing_checker.sv
`timescale 1ns/1ps
`include "ccd_config.svh"

module ccd_timing_checker (
	input  logic               pixclk,
	input  logic               reset,
	input  logic               i_xsub,
	input  logic               i_xsg,
	input  logic               i_strobe,
	input  logic               i_integration,
	input  logic               i_exp_over,
	input  logic               i_frame_done,
	input  ccd_pkg::line_cnt_t i_vcount,
	input  int                 i_test,          // table row in flight
	input  int                 i_integ_cycles,  // expected integration width
	input  int                 i_xsub_cycles,   // expected shutter low time
	input  logic               i_expect_idle,   // no exposure may start now
	output int                 o_frames,
	output int                 o_errors,
	output int                 o_checks
);
	import ccd_pkg::*;

	int        cyc;            // samples since reset
	int        integ_cnt;
	int        integ_rises;
	int        xsub_cnt;       // samples with o_xsub low
	int        xsg_cnt;
	int        xsg_rises;
	int        over_cnt;
	int        strobe_t;
	int        integ_t;
	int        fall_t;         // integration fall
	int        over_t;
	int        vmax;
	int        frame_errs;
	logic      idle_seen;      // one report per idle window
	logic      strobe_d;
	logic      integ_d;
	logic      xsg_d;
	logic      done_d;
	line_cnt_t vcount_d;

	task automatic compare_value(input string name, input int got, input int want);
		o_checks++;
		if (got != want) begin
			$display("[FAIL] test %0d %s: got 0x%0h expected 0x%0h", i_test, name, got, want);
			o_errors++;
			frame_errs++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("test %0d: %s", i_test, msg);
		o_errors++;
		frame_errs++;
	endtask

	task automatic clear_frame();
		integ_cnt   = 0;
		integ_rises = 0;
		xsub_cnt    = 0;
		xsg_cnt     = 0;
		xsg_rises   = 0;
		over_cnt    = 0;
		strobe_t    = -1;
		integ_t     = -1;
		fall_t      = -1;
		over_t      = -1;
		vmax        = 0;
		frame_errs  = 0;
	endtask

	// ------------------------------------------------------------
	// per frame summary, on frame_done
	// ------------------------------------------------------------
	task automatic finish_frame();
		compare_value("o_integration width", integ_cnt, i_integ_cycles);
		compare_value("o_integration pulses", integ_rises, 1);
		compare_value("o_xsub low cycles", xsub_cnt, i_xsub_cycles);
		compare_value("o_xsg width", xsg_cnt, `XSG_WIDTH);
		compare_value("o_xsg pulses", xsg_rises, 1);
		compare_value("o_exp_over cycles", over_cnt, 1);
		compare_value("o_exp_over delay", over_t - fall_t, 2);  // 2 after integ falls
		compare_value("o_vcount last line", vmax, `V_TOTAL);
		o_checks++;
		if (strobe_t < 0 || strobe_t >= integ_t)
			report_error("o_strobe did not rise before o_integration");
		$display("test %0d: integration %0d, shutter low %0d, lines %0d, %0d errors",
			i_test, integ_cnt, xsub_cnt, vmax, frame_errs);
		o_frames++;
		clear_frame();
	endtask

	// sampled on the rising edge, outputs hold their pre-edge values
	always @(posedge pixclk or posedge reset) begin
		if (reset) begin
			cyc       = 0;
			o_frames  = 0;
			o_errors  = 0;
			o_checks  = 0;
			idle_seen = 1'b0;
			strobe_d  = 1'b0;
			integ_d   = 1'b0;
			xsg_d     = 1'b0;
			done_d    = 1'b0;
			vcount_d  = '0;
			clear_frame();
		end else begin
			cyc++;
			if (!i_xsub)
				xsub_cnt++;
			if (i_integration)
				integ_cnt++;
			if (i_integration && !integ_d) begin
				integ_rises++;
				integ_t = cyc;
				if (!i_xsub)
					report_error("o_integration rose while o_xsub was still low");
			end
			if (!i_integration && integ_d)
				fall_t = cyc;
			if (i_strobe && !strobe_d)
				strobe_t = cyc;
			if (!i_strobe && strobe_d)
				compare_value("o_vcount at strobe fall", int'(i_vcount), 1);
			if (i_xsg)
				xsg_cnt++;
			if (i_xsg && !xsg_d)
				xsg_rises++;
			if (i_exp_over) begin
				over_cnt++;
				over_t = cyc;
			end
			// line counter steps by one, back to 0 only after the last line
			if (i_vcount != vcount_d) begin
				if (i_vcount == '0)
					compare_value("o_vcount before idle", int'(vcount_d), `V_TOTAL);
				else
					compare_value("o_vcount step", int'(i_vcount), int'(vcount_d) + 1);
				if (int'(i_vcount) > vmax)
					vmax = int'(i_vcount);
			end
			if (i_frame_done && done_d)
				report_error("o_frame_done stayed high for more than one cycle");
			if (i_expect_idle && !idle_seen &&
				(i_strobe || i_integration || i_xsg || i_vcount != '0)) begin
				report_error("an exposure started without a trigger");
				idle_seen = 1'b1;
			end
			if (!i_expect_idle)
				idle_seen = 1'b0;
			if (i_frame_done)
				finish_frame();
			strobe_d = i_strobe;
			integ_d  = i_integration;
			xsg_d    = i_xsg;
			done_d   = i_frame_done;
			vcount_d = i_vcount;
		end
	end

endmodule

//--- rtl/ccd_timing_top.sv
`timescale 1ns/1ps

module ccd_timing_top (
	input  logic                pixclk,
	input  logic                reset,
	input  ccd_pkg::trig_mode_e i_trig_mode,
	input  logic                i_trigger,
	input  ccd_pkg::exp_cnt_t   i_exposure_reg,
	output logic                o_xsub,
	output logic                o_xsg,
	output logic                o_strobe,
	output logic                o_integration,
	output logic                o_exp_over,
	output logic                o_frame_done,
	output ccd_pkg::line_cnt_t  o_vcount
);

	ccd_exp_if exp_bus ();   // trigger / exposure / readout strobes

	// ------------------------------------------------------------
	// block instances
	// ------------------------------------------------------------
	ccd_trigger_ctrl ccd_trigger_ctrl_inst (
		.pixclk      (pixclk),
		.reset       (reset),
		.i_trig_mode (i_trig_mode),
		.i_trigger   (i_trigger),
		.bus         (exp_bus.trig)
	);

	ccd_exp ccd_exp_inst (
		.pixclk             (pixclk),
		.reset              (reset),
		.i_trig_mode        (i_trig_mode),
		.i_exposure_reg     (i_exposure_reg),
		.bus                (exp_bus.exp),
		.o_xsub             (o_xsub),
		.o_strobe           (o_strobe),
		.o_integration      (o_integration),
		.o_exposure_preflag ()              // not brought out, no AFE here
	);

	ccd_readout_seq ccd_readout_seq_inst (
		.pixclk (pixclk),
		.reset  (reset),
		.bus    (exp_bus.rdo),
		.o_xsg  (o_xsg)
	);

	// bus status out to the pins
	assign o_exp_over   = exp_bus.exp_over;
	assign o_frame_done = exp_bus.frame_done;
	assign o_vcount     = exp_bus.vcount;

endmodule

//--- rtl/ccd_readout_seq.sv
`timescale 1ns/1ps
`include "ccd_config.svh"

module ccd_readout_seq (
	input  logic    pixclk,
	input  logic    reset,
	ccd_exp_if.rdo  bus,
	output logic    o_xsg             // transfer gate pulse
);
	import ccd_pkg::*;

	localparam int XW = $clog2(`XSG_WIDTH);
	localparam int HW = $clog2(`H_TOTAL);

	localparam logic [XW-1:0] XSG_LAST = XW'(`XSG_WIDTH - 1);
	localparam logic [HW-1:0] H_LAST   = HW'(`H_TOTAL - 1);
	localparam line_cnt_t     V_LAST   = line_cnt_t'(`V_TOTAL);

	typedef enum logic [1:0] {
		RD_IDLE = 2'd0,
		RD_XSG  = 2'd1,   // transfer gate high
		RD_LINE = 2'd2    // vertical shift, line by line
	} rd_state_e;

	rd_state_e       state;
	logic [XW-1:0]   xsg_cnt;
	logic [HW-1:0]   hcnt;         // pixel position in line
	line_cnt_t       vcount_q;
	logic            frame_done_q;

	// ------------------------------------------------------------
	// readout FSM
	// ------------------------------------------------------------
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			state        <= RD_IDLE;
			o_xsg        <= 1'b0;
			xsg_cnt      <= '0;
			hcnt         <= '0;
			vcount_q     <= '0;
			frame_done_q <= 1'b0;
		end else begin
			frame_done_q <= 1'b0;           // pulse by default low
			case (state)
				RD_IDLE: begin
					if (bus.xsg_start) begin
						o_xsg   <= 1'b1;        // gate opens next cycle
						xsg_cnt <= '0;
						state   <= RD_XSG;
					end
				end
				RD_XSG: begin
					if (xsg_cnt == XSG_LAST) begin
						o_xsg    <= 1'b0;
						hcnt     <= '0;
						vcount_q <= line_cnt_t'(1);  // first line
						state    <= RD_LINE;
					end else begin
						xsg_cnt <= xsg_cnt + XW'(1);
					end
				end
				RD_LINE: begin
					if (hcnt == H_LAST) begin
						hcnt <= '0;
						if (vcount_q == V_LAST) begin
							vcount_q     <= '0;     // idle reads 0
							frame_done_q <= 1'b1;
							state        <= RD_IDLE;
						end else begin
							vcount_q <= vcount_q + line_cnt_t'(1);
						end
					end else begin
						hcnt <= hcnt + HW'(1);
					end
				end
				default: begin
					state <= RD_IDLE;
					o_xsg <= 1'b0;
				end
			endcase
		end
	end

	assign bus.vcount     = vcount_q;
	assign bus.frame_done = frame_done_q;

	// exposure side must not request a transfer mid readout
	a_no_xsg_in_readout: assert property (@(posedge pixclk) disable iff (reset)
		bus.xsg_start |-> state == RD_IDLE);

endmodule

//--- rtl/ccd_exp.sv
`timescale 1ns/1ps
`include "ccd_config.svh"

module ccd_exp (
	input  logic                pixclk,
	input  logic                reset,
	input  ccd_pkg::trig_mode_e i_trig_mode,
	input  ccd_pkg::exp_cnt_t   i_exposure_reg,   // requested integration time
	ccd_exp_if.exp              bus,
	output logic                o_xsub,           // last shutter pulse, active low
	output logic                o_strobe,
	output logic                o_integration,
	output logic                o_exposure_preflag
);
	import ccd_pkg::*;

	localparam exp_cnt_t XSUB_CNT = exp_cnt_t'(`XSUB_WIDTH);
	localparam exp_cnt_t XSG_OFS  = exp_cnt_t'(`XSG1_FALLING);
	localparam exp_cnt_t MIN_REQ  = exp_cnt_t'(`XSG1_FALLING - `XSUB_WIDTH + 1);
	localparam exp_cnt_t MIN_EXP  = exp_cnt_t'(`XSG1_FALLING + 1);

	logic [1:0] start_shift;
	logic       start_edge;
	exp_cnt_t   exp_eff;        // shutter + integration, clamped
	exp_cnt_t   exp_cnt;
	exp_cnt_t   xsg_point;
	logic       xsub_last;      // internal shutter, low active
	logic       xsub_gate;      // shutter allowed out this exposure
	logic       exposure_flag;
	logic [1:0] integ_shift;
	logic       xsg_start_q;
	logic       exp_over_q;

	// ------------------------------------------------------------
	// start edge and effective exposure
	// ------------------------------------------------------------
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset)
			start_shift <= 2'b00;
		else
			start_shift <= {start_shift[0], bus.exposure_start};
	end

	assign start_edge = (start_shift == 2'b01);

	// short requests clamped so the transfer request fits
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			exp_eff <= MIN_EXP;
		end else if (start_edge) begin
			if (i_exposure_reg < MIN_REQ)
				exp_eff <= MIN_EXP;
			else
				exp_eff <= XSUB_CNT + i_exposure_reg;
		end
	end

	// saturating counter, parked at all ones out of reset
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset)
			exp_cnt <= '1;
		else if (start_edge)
			exp_cnt <= '0;
		else if (exp_cnt < exp_eff)
			exp_cnt <= exp_cnt + exp_cnt_t'(1);
	end

	assign xsg_point = exp_eff - XSG_OFS;

	// ------------------------------------------------------------
	// compare points
	// ------------------------------------------------------------
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			xsub_last          <= 1'b1;
			exposure_flag      <= 1'b0;
			o_exposure_preflag <= 1'b0;
			xsg_start_q        <= 1'b0;
		end else begin
			if (exp_cnt == '0)
				xsub_last <= 1'b0;          // shutter opens at count 0
			else if (exp_cnt == XSUB_CNT)
				xsub_last <= 1'b1;

			if (exp_cnt == XSUB_CNT)
				exposure_flag <= 1'b1;      // charge collection starts
			else if (exp_cnt == exp_eff)
				exposure_flag <= 1'b0;

			if (exp_cnt == '0)
				o_exposure_preflag <= 1'b1; // covers shutter + integration
			else if (exp_cnt == exp_eff)
				o_exposure_preflag <= 1'b0;

			xsg_start_q <= (exp_cnt == xsg_point);  // one shot, counter passes once
		end
	end

	// ------------------------------------------------------------
	// shutter output
	// ------------------------------------------------------------
	// gate sampled at the start edge so a short exposure keeps
	// a full shutter pulse after waitflag drops on xsg_start
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset)
			xsub_gate <= 1'b0;
		else if (start_edge)
			xsub_gate <= bus.waitflag;
	end

	always_ff @(posedge pixclk or posedge reset) begin
		if (reset)
			o_xsub <= 1'b1;
		else if (i_trig_mode == TRIG_EXTERNAL && xsub_gate)
			o_xsub <= xsub_last;
		else
			o_xsub <= 1'b1;             // free-run keeps shutter idle
	end

	// ------------------------------------------------------------
	// integration, exp_over, strobe
	// ------------------------------------------------------------
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			o_integration <= 1'b0;
			integ_shift   <= 2'b00;
			exp_over_q    <= 1'b0;
		end else begin
			o_integration <= exposure_flag;
			integ_shift   <= {integ_shift[0], o_integration};
			exp_over_q    <= (integ_shift == 2'b10);  // 2 cycles after fall
		end
	end

	always_ff @(posedge pixclk or posedge reset) begin
		if (reset)
			o_strobe <= 1'b0;
		else if (bus.vcount == line_cnt_t'(1))
			o_strobe <= 1'b0;           // first readout line
		else if (start_edge)
			o_strobe <= 1'b1;
	end

	assign bus.xsg_start = xsg_start_q;
	assign bus.exp_over  = exp_over_q;

	// shutter and integration never overlap
	a_no_xsub_in_integ: assert property (@(posedge pixclk) disable iff (reset)
		!(o_integration && !xsub_last));

	// transfer request leads the integration fall by a fixed offset
	a_xsg_leads_integ_end: assert property (@(posedge pixclk) disable iff (reset)
		$fell(o_integration) |-> $past(bus.xsg_start, `XSG1_FALLING + 1));

endmodule

//--- rtl/ccd_trigger_ctrl.sv
`timescale 1ns/1ps

module ccd_trigger_ctrl (
	input  logic                pixclk,
	input  logic                reset,
	input  ccd_pkg::trig_mode_e i_trig_mode,
	input  logic                i_trigger,     // async external trigger
	ccd_exp_if.trig             bus
);
	import ccd_pkg::*;

	typedef enum logic {
		ST_IDLE = 1'b0,   // no frame in flight
		ST_BUSY = 1'b1    // exposure or readout running
	} frame_state_e;

	frame_state_e state;
	logic [1:0]   trig_sync;     // two flop synchroniser
	logic         trig_d;        // previous synced level
	logic         trig_rise;
	logic         go;            // launch an exposure this cycle
	logic         start_q;
	logic         waitflag_q;

	// ------------------------------------------------------------
	// trigger input sync and edge detect
	// ------------------------------------------------------------
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			trig_sync <= 2'b00;
			trig_d    <= 1'b0;
		end else begin
			trig_sync <= {trig_sync[0], i_trigger};
			trig_d    <= trig_sync[1];
		end
	end

	assign trig_rise = trig_sync[1] & ~trig_d;

	// ------------------------------------------------------------
	// frame state and start pulse
	// ------------------------------------------------------------
	always_comb begin
		if (i_trig_mode == TRIG_FREERUN) begin
			// restart right on frame_done, or at once when idle
			go = (state == ST_IDLE) || bus.frame_done;
		end else begin
			go = (state == ST_IDLE) && trig_rise;  // busy drops triggers
		end
	end

	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			state   <= ST_IDLE;
			start_q <= 1'b0;
		end else begin
			start_q <= go;
			if (go)
				state <= ST_BUSY;
			else if (bus.frame_done)
				state <= ST_IDLE;
		end
	end

	// wait phase, only meaningful in trigger mode
	always_ff @(posedge pixclk or posedge reset) begin
		if (reset) begin
			waitflag_q <= 1'b1;
		end else if (i_trig_mode == TRIG_FREERUN) begin
			waitflag_q <= 1'b0;
		end else if (bus.xsg_start) begin
			waitflag_q <= 1'b0;         // readout begins
		end else if (bus.frame_done) begin
			waitflag_q <= 1'b1;         // back to waiting
		end
	end

	assign bus.exposure_start = start_q;
	assign bus.waitflag       = waitflag_q;

	// a triggered start never lands while a readout is running
	a_start_not_busy: assert property (@(posedge pixclk) disable iff (reset)
		bus.exposure_start && i_trig_mode == TRIG_EXTERNAL |-> bus.waitflag);

	// exp_over belongs to a frame this block has launched
	a_exp_over_in_frame: assert property (@(posedge pixclk) disable iff (reset)
		bus.exp_over |-> state == ST_BUSY);

endmodule

//--- rtl/ccd_exp_if.sv
`timescale 1ns/1ps

// exposure control strobes between trigger, exposure and readout
interface ccd_exp_if;
	import ccd_pkg::*;

	logic      exposure_start;  // one cycle, starts an exposure
	logic      waitflag;        // trigger mode, no readout running
	logic      xsg_start;       // transfer request from exposure
	logic      exp_over;        // end of integration, one cycle
	logic      frame_done;      // last line shifted out, one cycle
	line_cnt_t vcount;          // current readout line, 0 = idle

	// trigger controller
	modport trig (
		output exposure_start, waitflag,
		input  frame_done, exp_over, xsg_start
	);

	// exposure controller
	modport exp (
		output xsg_start, exp_over,
		input  exposure_start, waitflag, vcount
	);

	// readout sequencer
	modport rdo (
		output frame_done, vcount,
		input  xsg_start
	);

endinterface

//--- rtl/ccd_pkg.sv
`include "ccd_config.svh"

package ccd_pkg;

	// ------------------------------------------------------------
	// acquisition mode
	// ------------------------------------------------------------
	// free-run restarts exposure after every readout
	// external waits for a trigger edge per frame
	typedef enum logic {
		TRIG_FREERUN  = 1'b0,
		TRIG_EXTERNAL = 1'b1
	} trig_mode_e;

	// ------------------------------------------------------------
	// counter types
	// ------------------------------------------------------------
	typedef logic [`EXP_WD-1:0] exp_cnt_t;   // exposure length / counter
	typedef logic [`REG_WD-1:0] line_cnt_t;  // vertical line index

	// 0 while idle, 1..V_TOTAL while lines are shifted out
	// the exposure block watches for 1 to end the strobe

endpackage

//--- rtl/ccd_config.svh
`ifndef CCD_CONFIG_SVH
`define CCD_CONFIG_SVH

// ------------------------------------------------------------
// counter widths
// ------------------------------------------------------------
`define EXP_WD        24    // exposure count, pixel clocks
`define REG_WD        16    // vertical line count

// ------------------------------------------------------------
// exposure timing, pixel clocks
// ------------------------------------------------------------
// last electronic shutter pulse, placed right before integration
`define XSUB_WIDTH    8
// transfer request leads the end of integration by this much
// also sets the shortest exposure the sensor can take
`define XSG1_FALLING  20

// ------------------------------------------------------------
// readout geometry
// ------------------------------------------------------------
`define H_TOTAL       64    // pixel clocks per line
`define V_TOTAL       12    // lines per frame readout
`define XSG_WIDTH     6     // transfer gate pulse length

`endif
